//--- compile.f
+incdir+dv
verilog/vec_pkg.sv
verilog/vec_csr.sv
verilog/vec_regfile.sv
verilog/vec_bypass.sv
verilog/vec_alu.sv
verilog/vec_execute.sv
verilog/vec_unit.sv
dv/vec_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= vec_unit_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/vec_model.svh
// ************************************************************
// Reference model of the vector unit for the testbench.
// Keeps shadow registers and configuration and sets the
// expected writeback or reduction result for each issue.
// ************************************************************
`ifndef VEC_MODEL_SVH
`define VEC_MODEL_SVH

vec_data_t   model_regs [REG_COUNT];
vec_sew_e    model_sew;
vec_vl_t     model_vl;
vec_wb_t     exp_wb;
logic        exp_red_valid;
logic [31:0] exp_red_data;

function automatic int sew_bits(vec_sew_e sew);
    case (sew)
        SEW8:    return 8;
        SEW16:   return 16;
        default: return 32;
    endcase
endfunction

function automatic logic [31:0] sign_extend(logic [31:0] v, int w);
    return 32'($signed(v << (32 - w)) >>> (32 - w));
endfunction

// a and b hold one element each, zero-extended from w bits
function automatic logic [31:0] lane_result(vec_op_e op, logic [31:0] a, logic [31:0] b, int w);
    logic [31:0] sa;
    logic [31:0] sb;
    logic [4:0]  sh;
    sa = sign_extend(a, w);
    sb = sign_extend(b, w);
    sh = 5'(a & 32'(w - 1));
    case (op)
        OP_ADD:  return b + a;
        OP_SUB:  return b - a;
        OP_AND:  return b & a;
        OP_OR:   return b | a;
        OP_XOR:  return b ^ a;
        OP_SLL:  return b << sh;
        OP_SRL:  return b >> sh;
        OP_SRA:  return 32'($signed(sb) >>> sh);
        OP_MIN:  return ($signed(sb) < $signed(sa)) ? b : a;
        OP_MAX:  return ($signed(sb) > $signed(sa)) ? b : a;
        default: return 32'd0;
    endcase
endfunction

task automatic model_reset();
    for (int r = 0; r < REG_COUNT; r++) begin
        model_regs[r] = '0;
    end
    model_sew     = SEW32;
    model_vl      = 4'd2;
    exp_wb        = '0;
    exp_red_valid = 1'b0;
    exp_red_data  = '0;
endtask

task automatic model_config(input vec_sew_e sew, input vec_vl_t vl);
    int n;
    n = 64 / sew_bits(sew);
    model_sew = sew;
    model_vl  = (int'(vl) > n) ? 4'(n) : vl;
endtask

task automatic model_issue(input vec_instr_t ins);
    int          w;
    logic [31:0] emask;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sum;
    vec_data_t   src1;
    vec_data_t   src2;
    vec_data_t   res;
    vec_data_t   m;
    w     = sew_bits(model_sew);
    emask = (w == 32) ? 32'hFFFF_FFFF : ((32'd1 << w) - 32'd1);
    src1  = model_regs[ins.vs1];
    src2  = model_regs[ins.vs2];
    res   = model_regs[ins.vd];
    m     = model_regs[0];
    sum   = 32'(src1) & emask;
    for (int i = 0; i < 64 / w; i++) begin
        b = 32'(src2 >> (i * w)) & emask;
        case (ins.src)
            SRC_VV:  a = 32'(src1 >> (i * w)) & emask;
            SRC_VI:  a = {{27{ins.imm[4]}}, ins.imm} & emask;
            default: a = ins.scalar & emask;
        endcase
        if (i < int'(model_vl) && (!ins.use_mask || m[6'(i)])) begin
            res = (res & ~({32'd0, emask} << (i * w)))
                | ({32'd0, lane_result(ins.op, a, b, w) & emask} << (i * w));
            sum = (sum + b) & emask;
        end
    end
    if (ins.op == OP_REDSUM) begin
        exp_wb.valid  = 1'b0;
        exp_red_valid = 1'b1;
        exp_red_data  = sign_extend(sum, w);
    end else begin
        exp_wb             = '{valid: 1'b1, addr: ins.vd, data: res};
        exp_red_valid      = 1'b0;
        model_regs[ins.vd] = res;
    end
endtask

`endif

//--- dv/vec_unit_tb.sv
// ************************************************************
// Testbench for the vector unit. Drives LFSR-based random
// instructions and configuration writes and checks every
// result against the model one cycle after issue.
// ************************************************************
`timescale 1ns/1ns
`default_nettype none

module vec_unit_tb import vec_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_RANDOM   = 400;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 3 * (1 + REG_COUNT) + 3 * (1 + 11 * 3)
                                + NUM_RANDOM + 8;
    localparam int WATCHDOG_NS  = TOTAL_CYCLES * CLK_PERIOD + 2000;

    logic        clk;
    logic        rst;
    logic        cfg_we;
    vec_sew_e    cfg_sew;
    vec_vl_t     cfg_vl;
    logic        instr_valid;
    vec_instr_t  instr;
    logic        wb_valid;
    vec_addr_t   wb_addr;
    vec_data_t   wb_data;
    logic        red_valid;
    logic [31:0] red_data;

    logic [15:0] lfsr_state;
    vec_addr_t   last_vd;
    int          checks;
    int          errors;
    int          issued;

    `include "vec_model.svh"

    vec_unit i_vec_unit (
        .clk         (clk),
        .rst         (rst),
        .cfg_we      (cfg_we),
        .cfg_sew     (cfg_sew),
        .cfg_vl      (cfg_vl),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .red_valid   (red_valid),
        .red_data    (red_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per returned bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_outputs();
        check_value("wb_valid", 64'(wb_valid), 64'(exp_wb.valid));
        check_value("red_valid", 64'(red_valid), 64'(exp_red_valid));
        if (exp_wb.valid) begin
            check_value("wb_addr", 64'(wb_addr), 64'(exp_wb.addr));
            check_value("wb_data", wb_data, exp_wb.data);
        end
        if (exp_red_valid) begin
            check_value("red_data", 64'(red_data), 64'(exp_red_data));
        end
    endtask

    // Checks the previous issue, then drives the next one 2 ns after the edge
    task automatic run_cycle(input logic valid, input vec_instr_t ins, input logic we,
                             input vec_sew_e sew, input vec_vl_t vl);
        @(posedge clk);
        #1;
        check_outputs();
        #1;
        instr_valid = valid;
        instr       = ins;
        cfg_we      = we;
        cfg_sew     = sew;
        cfg_vl      = vl;
        if (valid) begin
            model_issue(ins);
            last_vd = ins.vd;
            issued++;
        end else begin
            exp_wb.valid  = 1'b0;
            exp_red_valid = 1'b0;
        end
        if (we) begin
            model_config(sew, vl);
        end
    endtask

    task automatic issue(input vec_instr_t ins);
        run_cycle(1'b1, ins, 1'b0, cfg_sew, cfg_vl);
    endtask

    task automatic configure(input vec_sew_e sew, input vec_vl_t vl);
        run_cycle(1'b0, '0, 1'b1, sew, vl);
    endtask

    task automatic make_random_instr(output vec_instr_t ins);
        ins.op       = vec_op_e'(4'(rand_bits(4) % 32'd11));
        ins.src      = vec_src_e'(2'(rand_bits(2) % 32'd3));
        ins.vd       = 3'(rand_bits(3));
        ins.vs1      = 3'(rand_bits(3));
        ins.vs2      = 3'(rand_bits(3));
        ins.imm      = 5'(rand_bits(5));
        ins.scalar   = rand_bits(32);
        ins.use_mask = 1'(rand_bits(1));
        // Lean on the previous destination so the bypass gets exercised
        case (2'(rand_bits(2)))
            2'd0:    ins.vs2 = last_vd;
            2'd1:    ins.vs1 = last_vd;
            default: ins.vd  = last_vd;
        endcase
        if (rand_bits(3) == 32'd0) begin
            ins.vd = '0;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        vec_instr_t ins;
        logic       valid;
        logic       we;
        vec_sew_e   sew;
        vec_vl_t    vl;
        rst         = 1'b1;
        cfg_we      = 1'b0;
        cfg_sew     = SEW32;
        cfg_vl      = '0;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr_state  = 16'd33006;
        last_vd     = '0;
        checks      = 0;
        errors      = 0;
        issued      = 0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        // Idle after reset, then an add of two cleared registers
        run_cycle(1'b0, '0, 1'b0, SEW32, '0);
        run_cycle(1'b0, '0, 1'b0, SEW32, '0);
        ins = '{op: OP_ADD, src: SRC_VV, vd: 3'd1, vs1: 3'd2, vs2: 3'd3,
                imm: '0, scalar: '0, use_mask: 1'b0};
        issue(ins);

        // Fill every register with patterns at each SEW
        for (int s = 0; s < 3; s++) begin
            configure(vec_sew_e'(2'(s)), 4'd8);
            for (int r = 0; r < REG_COUNT; r++) begin
                make_random_instr(ins);
                ins = '{op: OP_XOR, src: SRC_VX, vd: 3'(r), vs1: 3'(r), vs2: 3'(r),
                        imm: '0, scalar: ins.scalar, use_mask: 1'b0};
                issue(ins);
            end
        end

        // Every opcode and form at each SEW, vl requested above the limit
        for (int s = 0; s < 3; s++) begin
            configure(vec_sew_e'(2'(s)), 4'd15);
            for (int op = 0; op < 11; op++) begin
                for (int src = 0; src < 3; src++) begin
                    make_random_instr(ins);
                    ins.op  = vec_op_e'(4'(op));
                    ins.src = vec_src_e'(2'(src));
                    issue(ins);
                end
            end
        end

        // Random mix with occasional configuration writes and bubbles
        for (int n = 0; n < NUM_RANDOM; n++) begin
            make_random_instr(ins);
            valid = (rand_bits(3) != 32'd0);
            we    = (rand_bits(4) == 32'd0);
            sew   = we ? vec_sew_e'(2'(rand_bits(2) % 32'd3)) : cfg_sew;
            vl    = we ? 4'(rand_bits(4)) : cfg_vl;
            run_cycle(valid, ins, we, sew, vl);
        end

        run_cycle(1'b0, '0, 1'b0, cfg_sew, cfg_vl);
        run_cycle(1'b0, '0, 1'b0, cfg_sew, cfg_vl);

        $display("Checks: %0d, errors: %0d, instructions: %0d", checks, errors, issued);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/vec_unit.sv
// ************************************************************
// Vector execute subsystem top level. Issue one instruction
// per cycle on instr_valid; results appear one cycle later
// on the wb_* or red_* outputs.
// ************************************************************
`timescale 1ns/1ns
`default_nettype none

module vec_unit import vec_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cfg_we,
    input  vec_sew_e    cfg_sew,
    input  vec_vl_t     cfg_vl,
    input  logic        instr_valid,
    input  vec_instr_t  instr,
    output logic        wb_valid,
    output vec_addr_t   wb_addr,
    output vec_data_t   wb_data,
    output logic        red_valid,
    output logic [31:0] red_data
);

    vec_cfg_t  cfg;
    vec_wb_t   wb;
    vec_addr_t rd_addr_a;
    vec_addr_t rd_addr_b;
    vec_addr_t rd_addr_d;
    vec_data_t rd_data_a;
    vec_data_t rd_data_b;
    vec_data_t rd_data_d;
    vec_data_t mask_data;

    vec_csr i_vec_csr (
        .clk     (clk),
        .rst     (rst),
        .cfg_we  (cfg_we),
        .cfg_sew (cfg_sew),
        .cfg_vl  (cfg_vl),
        .cfg     (cfg)
    );

    vec_regfile i_vec_regfile (
        .clk       (clk),
        .rst       (rst),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_addr_d (rd_addr_d),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .rd_data_d (rd_data_d),
        .mask_data (mask_data),
        .wb        (wb)
    );

    vec_execute i_vec_execute (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .cfg         (cfg),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .rd_addr_d   (rd_addr_d),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .rd_data_d   (rd_data_d),
        .mask_data   (mask_data),
        .wb          (wb),
        .red_valid   (red_valid),
        .red_data    (red_data)
    );

    assign wb_valid = wb.valid;
    assign wb_addr  = wb.addr;
    assign wb_data  = wb.data;

endmodule

`default_nettype wire

//--- verilog/vec_execute.sv
// ************************************************************
// Execute stage. Reads operands, applies wb bypass, runs the
// lane ALU and registers either the writeback or the
// reduction result one cycle after issue.
// ************************************************************
`timescale 1ns/1ns
`default_nettype none

module vec_execute import vec_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        instr_valid,
    input  vec_instr_t  instr,
    input  vec_cfg_t    cfg,
    output vec_addr_t   rd_addr_a,
    output vec_addr_t   rd_addr_b,
    output vec_addr_t   rd_addr_d,
    input  vec_data_t   rd_data_a,
    input  vec_data_t   rd_data_b,
    input  vec_data_t   rd_data_d,
    input  vec_data_t   mask_data,
    output vec_wb_t     wb,
    output logic        red_valid,
    output logic [31:0] red_data
);

    vec_data_t   byp_a;
    vec_data_t   byp_b;
    vec_data_t   byp_d;
    vec_data_t   byp_mask;
    vec_data_t   alu_result;
    logic [31:0] alu_red_sum;
    logic        is_red;
    logic        is_write;
    logic        wb_valid_q;
    vec_addr_t   wb_addr_q;
    vec_data_t   wb_data_q;

    assign rd_addr_a = instr.vs1;
    assign rd_addr_b = instr.vs2;
    assign rd_addr_d = instr.vd;

    vec_bypass i_vec_bypass (
        .wb       (wb),
        .addr_a   (instr.vs1),
        .addr_b   (instr.vs2),
        .addr_d   (instr.vd),
        .rf_a     (rd_data_a),
        .rf_b     (rd_data_b),
        .rf_d     (rd_data_d),
        .rf_mask  (mask_data),
        .byp_a    (byp_a),
        .byp_b    (byp_b),
        .byp_d    (byp_d),
        .byp_mask (byp_mask)
    );

    vec_alu i_vec_alu (
        .instr   (instr),
        .cfg     (cfg),
        .src_a   (byp_a),
        .src_b   (byp_b),
        .old_d   (byp_d),
        .mask    (byp_mask),
        .result  (alu_result),
        .red_sum (alu_red_sum)
    );

    assign is_red   = instr_valid && (instr.op == OP_REDSUM);
    assign is_write = instr_valid && (instr.op != OP_REDSUM);

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_q <= 1'b0;
            red_valid  <= 1'b0;
        end else begin
            wb_valid_q <= is_write;
            red_valid  <= is_red;
        end
    end

    always_ff @(posedge clk) begin
        if (is_write) begin
            wb_addr_q <= instr.vd;
            wb_data_q <= alu_result;
        end
        if (is_red) begin
            red_data <= alu_red_sum;
        end
    end

    assign wb = '{valid: wb_valid_q, addr: wb_addr_q, data: wb_data_q};

endmodule

`default_nettype wire

//--- verilog/vec_alu.sv
// ************************************************************
// Lane ALU for SEW 8/16/32. Computes vs2 OP operand a per
// element, merges with old vd under mask and vl, and
// produces the reduction sum on a separate output.
// ************************************************************
`timescale 1ns/1ns
`default_nettype none

module vec_alu import vec_pkg::*; (
    input  vec_instr_t  instr,
    input  vec_cfg_t    cfg,
    input  vec_data_t   src_a,
    input  vec_data_t   src_b,
    input  vec_data_t   old_d,
    input  vec_data_t   mask,
    output vec_data_t   result,
    output logic [31:0] red_sum
);

    function automatic logic [31:0] sext_sew(logic [31:0] v, vec_sew_e sew);
        case (sew)
            SEW8:    return 32'($signed(v[7:0]));
            SEW16:   return 32'($signed(v[15:0]));
            default: return v;
        endcase
    endfunction

    function automatic logic [31:0] get_elem(vec_data_t d, logic [2:0] idx, vec_sew_e sew);
        logic [31:0] raw;
        case (sew)
            SEW8:    raw = 32'(d[idx*8 +: 8]);
            SEW16:   raw = 32'(d[idx[1:0]*16 +: 16]);
            default: raw = d[idx[0]*32 +: 32];
        endcase
        return sext_sew(raw, sew);
    endfunction

    function automatic vec_data_t put_elem(vec_data_t d, logic [2:0] idx, vec_sew_e sew,
                                           logic [31:0] v);
        vec_data_t r;
        r = d;
        case (sew)
            SEW8:    r[idx*8 +: 8]          = v[7:0];
            SEW16:   r[idx[1:0]*16 +: 16]   = v[15:0];
            default: r[idx[0]*32 +: 32]     = v;
        endcase
        return r;
    endfunction

    // Operands arrive sign-extended from SEW to 32 bits
    function automatic logic [31:0] lane_op(vec_op_e op, logic [31:0] a, logic [31:0] b,
                                            vec_sew_e sew);
        logic [4:0]  shamt;
        logic [31:0] b_zext;
        case (sew)
            SEW8: begin
                shamt  = {2'b00, a[2:0]};
                b_zext = {24'd0, b[7:0]};
            end
            SEW16: begin
                shamt  = {1'b0, a[3:0]};
                b_zext = {16'd0, b[15:0]};
            end
            default: begin
                shamt  = a[4:0];
                b_zext = b;
            end
        endcase
        case (op)
            OP_ADD:  return b + a;
            OP_SUB:  return b - a;
            OP_AND:  return b & a;
            OP_OR:   return b | a;
            OP_XOR:  return b ^ a;
            OP_SLL:  return b << shamt;
            OP_SRL:  return b_zext >> shamt;
            OP_SRA:  return $signed(b) >>> shamt;
            OP_MIN:  return ($signed(b) < $signed(a)) ? b : a;
            OP_MAX:  return ($signed(b) > $signed(a)) ? b : a;
            default: return b;
        endcase
    endfunction

    logic [31:0] scalar_a;

    // Scalar or immediate, already truncated and sign-extended per SEW
    assign scalar_a = (instr.src == SRC_VI) ? sext_sew(32'($signed(instr.imm)), cfg.sew)
                                            : sext_sew(instr.scalar, cfg.sew);

    always_comb begin
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic        active;
        logic [31:0] sum;
        result = old_d;
        sum    = get_elem(src_a, 3'd0, cfg.sew);
        for (int i = 0; i < 8; i++) begin
            op_a   = (instr.src == SRC_VV) ? get_elem(src_a, 3'(i), cfg.sew) : scalar_a;
            op_b   = get_elem(src_b, 3'(i), cfg.sew);
            active = (4'(i) < cfg.vl) && (!instr.use_mask || mask[i]);
            if (active) begin
                result = put_elem(result, 3'(i), cfg.sew, lane_op(instr.op, op_a, op_b, cfg.sew));
                sum    = sum + op_b;
            end
        end
        // Wraps at SEW, then back to 32 bits
        red_sum = sext_sew(sum, cfg.sew);
    end

endmodule

`default_nettype wire

//--- verilog/vec_bypass.sv
// ************************************************************
// Operand forwarding from the writeback register.
// The register file writes one cycle after wb, so a reader
// in that cycle takes wb data instead.
// ************************************************************
`timescale 1ns/1ns
`default_nettype none

module vec_bypass import vec_pkg::*; (
    input  vec_wb_t   wb,
    input  vec_addr_t addr_a,
    input  vec_addr_t addr_b,
    input  vec_addr_t addr_d,
    input  vec_data_t rf_a,
    input  vec_data_t rf_b,
    input  vec_data_t rf_d,
    input  vec_data_t rf_mask,
    output vec_data_t byp_a,
    output vec_data_t byp_b,
    output vec_data_t byp_d,
    output vec_data_t byp_mask
);

    logic hit_a;
    logic hit_b;
    logic hit_d;
    logic hit_mask;

    assign hit_a    = wb.valid && (wb.addr == addr_a);
    assign hit_b    = wb.valid && (wb.addr == addr_b);
    assign hit_d    = wb.valid && (wb.addr == addr_d);
    assign hit_mask = wb.valid && (wb.addr == '0);

    assign byp_a    = hit_a    ? wb.data : rf_a;
    assign byp_b    = hit_b    ? wb.data : rf_b;
    assign byp_d    = hit_d    ? wb.data : rf_d;
    assign byp_mask = hit_mask ? wb.data : rf_mask;

endmodule

`default_nettype wire

//--- verilog/vec_regfile.sv
// ************************************************************
// Eight 64-bit vector registers with three combinational
// read ports, a dedicated v0 mask port and one write port.
// ************************************************************
`timescale 1ns/1ns
`default_nettype none

module vec_regfile import vec_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  vec_addr_t rd_addr_a,
    input  vec_addr_t rd_addr_b,
    input  vec_addr_t rd_addr_d,
    output vec_data_t rd_data_a,
    output vec_data_t rd_data_b,
    output vec_data_t rd_data_d,
    output vec_data_t mask_data,
    input  vec_wb_t   wb
);

    vec_data_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.addr] <= wb.data;
        end
    end

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];
    assign rd_data_d = regs[rd_addr_d];

    // v0 always carries the element mask
    assign mask_data = regs[0];

endmodule

`default_nettype wire

//--- verilog/vec_csr.sv
// ************************************************************
// Vector configuration register holding SEW and vl.
// A write clamps vl to the element count of the new SEW.
// ************************************************************
`timescale 1ns/1ns
`default_nettype none

module vec_csr import vec_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     cfg_we,
    input  vec_sew_e cfg_sew,
    input  vec_vl_t  cfg_vl,
    output vec_cfg_t cfg
);

    vec_sew_e sew_legal;
    vec_vl_t  vl_max;
    vec_vl_t  vl_clamped;
    vec_cfg_t cfg_q;

    // Reserved SEW encoding falls back to 32-bit elements
    always_comb begin
        case (cfg_sew)
            SEW8, SEW16, SEW32: sew_legal = cfg_sew;
            default:            sew_legal = SEW32;
        endcase
    end

    assign vl_max     = elem_count(sew_legal);
    assign vl_clamped = (cfg_vl > vl_max) ? vl_max : cfg_vl;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q.sew <= SEW32;
            cfg_q.vl  <= 4'd2;
        end else if (cfg_we) begin
            cfg_q.sew <= sew_legal;
            cfg_q.vl  <= vl_clamped;
        end
    end

    assign cfg = cfg_q;

endmodule

`default_nettype wire

//--- verilog/vec_pkg.sv
// ************************************************************
// Shared widths, encodings and bundles for the vector unit.
// Imported by every RTL block and by the testbench.
// ************************************************************
`default_nettype none

package vec_pkg;

    localparam int VLEN      = 64;
    localparam int REG_COUNT = 8;

    typedef logic [VLEN-1:0]              vec_data_t;
    typedef logic [$clog2(REG_COUNT)-1:0] vec_addr_t;
    typedef logic [3:0]                   vec_vl_t;

    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } vec_sew_e;

    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_AND    = 4'd2,
        OP_OR     = 4'd3,
        OP_XOR    = 4'd4,
        OP_SLL    = 4'd5,
        OP_SRL    = 4'd6,
        OP_SRA    = 4'd7,
        OP_MIN    = 4'd8,
        OP_MAX    = 4'd9,
        OP_REDSUM = 4'd10
    } vec_op_e;

    typedef enum logic [1:0] {
        SRC_VV = 2'd0,
        SRC_VX = 2'd1,
        SRC_VI = 2'd2
    } vec_src_e;

    typedef struct packed {
        vec_sew_e sew;
        vec_vl_t  vl;
    } vec_cfg_t;

    typedef struct packed {
        vec_op_e     op;
        vec_src_e    src;
        vec_addr_t   vd;
        vec_addr_t   vs1;
        vec_addr_t   vs2;
        logic [4:0]  imm;
        logic [31:0] scalar;
        logic        use_mask;
    } vec_instr_t;

    typedef struct packed {
        logic      valid;
        vec_addr_t addr;
        vec_data_t data;
    } vec_wb_t;

    // Elements per register for a given SEW
    function automatic vec_vl_t elem_count(vec_sew_e sew);
        case (sew)
            SEW8:    return 4'd8;
            SEW16:   return 4'd4;
            default: return 4'd2;
        endcase
    endfunction

endpackage

`default_nettype wire
